/* verilog/asm_params.svh */
`ifndef ASM_PARAMS_SVH
`define ASM_PARAMS_SVH

// byte lanes per beat
`define ASM_BEAT_BYTES 64

// ethernet (14) plus ipv4 (20) header bytes
`define ASM_HDR_BYTES 34

// cycles from header load to a valid checksum
`define ASM_CSUM_LAT 5

// first ipv4 byte inside the header
`define ASM_IP_BASE 14

// two-byte total-length field
`define ASM_IP_LEN_OFS 16

// two-byte header checksum field
`define ASM_IP_CSUM_OFS 24

// ipv4 header is ten 16-bit words
`define ASM_IP_WORDS 10

`endif

/* verilog/asm_pkg.sv */
`include "asm_params.svh"

package asm_pkg;

    // one beat of byte lanes with byte i in bits [8*i +: 8]
    typedef logic [`ASM_BEAT_BYTES*8-1:0] beat_t;

    // one valid bit per lane
    typedef logic [`ASM_BEAT_BYTES-1:0] keep_t;

    // header template in the same lane order as a beat
    typedef logic [`ASM_HDR_BYTES*8-1:0] hdr_t;

    // network order field with the lower-indexed byte in bits [15:8]
    typedef logic [15:0] word16_t;

    // adder accumulator, wide enough for ten words without overflow
    typedef logic [19:0] csum_acc_t;

endpackage

/* verilog/stage_pipe.sv */
`timescale 1ns/10ps

module stage_pipe #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 1
) (
    input  logic     clk,
    input  logic     rst,
    input  payload_t d,
    output payload_t q
);

    payload_t stages [DEPTH];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                stages[i] <= '0;
            end
        end else begin
            stages[0] <= d;
            for (int i = 1; i < DEPTH; i++) begin
                stages[i] <= stages[i-1];
            end
        end
    end

    assign q = stages[DEPTH-1];

    // a zero-depth line would leave q without a register behind it
    depth_ok: assert property (@(posedge clk) disable iff (rst) DEPTH >= 1);

endmodule

/* verilog/csum_tree.sv */
`timescale 1ns/10ps

`include "asm_params.svh"

module csum_tree import asm_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    hdr_load,
    input  hdr_t    hdr_in,
    input  word16_t len_q,
    output word16_t csum,
    output logic    csum_valid
);

    localparam int LEN_W  = (`ASM_IP_LEN_OFS - `ASM_IP_BASE) / 2;
    localparam int CSUM_W = (`ASM_IP_CSUM_OFS - `ASM_IP_BASE) / 2;

    word16_t   words [`ASM_IP_WORDS];
    csum_acc_t lvl1 [5];
    csum_acc_t lvl2 [3];
    csum_acc_t lvl3;
    csum_acc_t fold1;
    logic [16:0] fold2_sum;
    logic [3:0]  vld;

    // network order word k of the ipv4 header
    function automatic word16_t ip_word(hdr_t h, int unsigned k);
        int unsigned b;
        b = `ASM_IP_BASE + 2 * k;
        return {h[8*b +: 8], h[8*(b+1) +: 8]};
    endfunction

    // length comes from the latched value and the checksum field counts as zero
    always_comb begin
        for (int k = 0; k < `ASM_IP_WORDS; k++) begin
            words[k] = ip_word(hdr_in, k);
        end
        words[LEN_W]  = len_q;
        words[CSUM_W] = '0;
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < 5; p++) begin
            lvl1[p] <= csum_acc_t'(words[2*p]) + csum_acc_t'(words[2*p+1]);
        end
        lvl2[0] <= lvl1[0] + lvl1[1];
        lvl2[1] <= lvl1[2] + lvl1[3];
        lvl2[2] <= lvl1[4];
        lvl3    <= lvl2[0] + lvl2[1] + lvl2[2];
        // first fold leaves at most one carry
        fold1   <= csum_acc_t'(lvl3[15:0]) + csum_acc_t'(lvl3[19:16]);
    end

    assign fold2_sum = {1'b0, fold1[15:0]} + {13'b0, fold1[19:16]};

    // checksum holds until the next header works its way through
    always_ff @(posedge clk) begin
        if (vld[3]) begin
            csum <= ~fold2_sum[15:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vld        <= '0;
            csum_valid <= 1'b0;
        end else begin
            vld        <= {vld[2:0], hdr_load};
            csum_valid <= vld[3];
        end
    end

    // two folds are always enough for ten 16-bit words
    fold_no_carry: assert property (
        @(posedge clk) disable iff (rst) vld[3] |-> !fold2_sum[16]
    );

endmodule

/* verilog/beat_realigner.sv */
`timescale 1ns/10ps

`include "asm_params.svh"

module beat_realigner import asm_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  in_valid,
    input  beat_t in_data,
    input  keep_t in_keep,
    input  logic  in_last,
    output logic  sh_valid,
    output beat_t sh_data,
    output keep_t sh_keep,
    output logic  sh_last,
    output logic  sh_first
);

    localparam int BEAT = `ASM_BEAT_BYTES;
    localparam int HDR  = `ASM_HDR_BYTES;
    // lanes of an input beat that still fit into the same output beat
    localparam int LOW  = BEAT - HDR;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BODY,
        ST_FLUSH
    } state_t;

    state_t state;

    logic [HDR*8-1:0] carry_data;
    logic [HDR-1:0]   carry_keep;
    logic             tail_kept;
    logic             end_now;

    // top lanes of this beat spill into a following beat
    assign tail_kept = |in_keep[BEAT-1:LOW];
    assign end_now   = in_valid && in_last;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= ST_IDLE;
            sh_valid <= 1'b0;
            sh_first <= 1'b0;
            sh_last  <= 1'b0;
        end else begin
            case (state)
                ST_IDLE, ST_BODY: begin
                    sh_valid <= in_valid;
                    sh_first <= in_valid && (state == ST_IDLE);
                    sh_last  <= end_now && !tail_kept;
                    if (end_now) begin
                        state <= tail_kept ? ST_FLUSH : ST_IDLE;
                    end else if (in_valid) begin
                        state <= ST_BODY;
                    end
                end
                ST_FLUSH: begin
                    sh_valid <= 1'b1;
                    sh_first <= 1'b0;
                    sh_last  <= 1'b1;
                    state    <= ST_IDLE;
                end
                default: begin
                    sh_valid <= 1'b0;
                    sh_first <= 1'b0;
                    sh_last  <= 1'b0;
                    state    <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_FLUSH) begin
            sh_data <= {{(LOW*8){1'b0}}, carry_data};
            sh_keep <= {{LOW{1'b0}}, carry_keep};
        end else if (in_valid) begin
            // header lanes of a first beat are filled in downstream
            sh_data[HDR*8-1:0]    <= (state == ST_IDLE) ? '0 : carry_data;
            sh_keep[HDR-1:0]      <= (state == ST_IDLE) ? '0 : carry_keep;
            sh_data[BEAT*8-1:HDR*8] <= in_data[LOW*8-1:0];
            sh_keep[BEAT-1:HDR]     <= in_keep[LOW-1:0];
            carry_data <= in_data[BEAT*8-1:LOW*8];
            carry_keep <= in_keep[BEAT-1:LOW];
        end
    end

    no_input_in_flush: assert property (
        @(posedge clk) disable iff (rst) (state == ST_FLUSH) |-> !in_valid
    );

    keep_contiguous: assert property (
        @(posedge clk) disable iff (rst) in_valid |-> ((in_keep & (in_keep + 1'b1)) == '0)
    );

    no_double_last: assert property (
        @(posedge clk) disable iff (rst) end_now |=> !end_now
    );

endmodule

/* verilog/header_merge.sv */
`timescale 1ns/10ps

`include "asm_params.svh"

module header_merge import asm_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    len_load,
    input  word16_t len_in,
    input  logic    hdr_load,
    input  hdr_t    hdr_in,
    input  word16_t csum,
    input  logic    csum_valid,
    input  logic    sh_valid,
    input  beat_t   sh_data,
    input  keep_t   sh_keep,
    input  logic    sh_last,
    input  logic    sh_first,
    output word16_t len_q,
    output logic    out_valid,
    output beat_t   out_data,
    output keep_t   out_keep,
    output logic    out_last
);

    localparam int HDR = `ASM_HDR_BYTES;

    typedef struct packed {
        logic load;
        hdr_t hdr;
    } hdr_slot_t;

    hdr_slot_t hdr_slot_in;
    hdr_slot_t hdr_slot_out;
    word16_t   len_snap;
    hdr_t      merged;
    logic      hdr_pending;

    // overwrite one network order field of the header
    function automatic hdr_t put_word(hdr_t h, int unsigned ofs, word16_t w);
        hdr_t r;
        r = h;
        r[8*ofs +: 8]     = w[15:8];
        r[8*(ofs+1) +: 8] = w[7:0];
        return r;
    endfunction

    always_ff @(posedge clk) begin
        if (len_load) begin
            len_q <= len_in;
        end
    end

    assign hdr_slot_in.load = hdr_load;
    assign hdr_slot_in.hdr  = hdr_in;

    // template and length wait for the checksum
    stage_pipe #(.payload_t(hdr_slot_t), .DEPTH(`ASM_CSUM_LAT)) hdr_pipe (
        .clk (clk),
        .rst (rst),
        .d   (hdr_slot_in),
        .q   (hdr_slot_out)
    );

    stage_pipe #(.payload_t(word16_t), .DEPTH(`ASM_CSUM_LAT)) len_pipe (
        .clk (clk),
        .rst (rst),
        .d   (len_q),
        .q   (len_snap)
    );

    always_ff @(posedge clk) begin
        if (csum_valid && hdr_slot_out.load) begin
            merged <= put_word(put_word(hdr_slot_out.hdr, `ASM_IP_LEN_OFS, len_snap),
                               `ASM_IP_CSUM_OFS, csum);
        end
    end

    // set by a load and cleared once its merged header is written
    always_ff @(posedge clk) begin
        if (rst) begin
            hdr_pending <= 1'b0;
        end else if (hdr_load) begin
            hdr_pending <= 1'b1;
        end else if (hdr_slot_out.load) begin
            hdr_pending <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end else begin
            out_valid <= sh_valid;
            out_last  <= sh_valid && sh_last;
        end
    end

    always_ff @(posedge clk) begin
        if (sh_valid) begin
            out_data <= sh_first ? {sh_data[$bits(beat_t)-1:HDR*8], merged} : sh_data;
            out_keep <= sh_first ? {sh_keep[$bits(keep_t)-1:HDR], {HDR{1'b1}}} : sh_keep;
        end
    end

    header_ready: assert property (
        @(posedge clk) disable iff (rst) (sh_valid && sh_first) |-> !hdr_pending
    );

endmodule

/* verilog/stream_assembler.sv */
`timescale 1ns/10ps

module stream_assembler import asm_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    len_load,
    input  word16_t len_in,
    input  logic    hdr_load,
    input  hdr_t    hdr_in,
    input  logic    in_valid,
    input  beat_t   in_data,
    input  keep_t   in_keep,
    input  logic    in_last,
    output logic    out_valid,
    output beat_t   out_data,
    output keep_t   out_keep,
    output logic    out_last
);

    word16_t len_q;
    word16_t csum;
    logic    csum_valid;
    logic    sh_valid;
    beat_t   sh_data;
    keep_t   sh_keep;
    logic    sh_last;
    logic    sh_first;

    csum_tree csum_tree_inst (
        .clk        (clk),
        .rst        (rst),
        .hdr_load   (hdr_load),
        .hdr_in     (hdr_in),
        .len_q      (len_q),
        .csum       (csum),
        .csum_valid (csum_valid)
    );

    beat_realigner beat_realigner_inst (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_data  (in_data),
        .in_keep  (in_keep),
        .in_last  (in_last),
        .sh_valid (sh_valid),
        .sh_data  (sh_data),
        .sh_keep  (sh_keep),
        .sh_last  (sh_last),
        .sh_first (sh_first)
    );

    header_merge header_merge_inst (
        .clk        (clk),
        .rst        (rst),
        .len_load   (len_load),
        .len_in     (len_in),
        .hdr_load   (hdr_load),
        .hdr_in     (hdr_in),
        .csum       (csum),
        .csum_valid (csum_valid),
        .sh_valid   (sh_valid),
        .sh_data    (sh_data),
        .sh_keep    (sh_keep),
        .sh_last    (sh_last),
        .sh_first   (sh_first),
        .len_q      (len_q),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_keep   (out_keep),
        .out_last   (out_last)
    );

endmodule

/* sim/tb_clock.sv */
`timescale 1ns/10ps

module tb_clock #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // reset drops on the falling edge after RESET_CYCLES rising edges
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

/* sim/stream_assembler_tb.sv */
`timescale 1ns/10ps

`include "asm_params.svh"

module stream_assembler_tb import asm_pkg::*; ();

    localparam int PERIOD     = 100;
    localparam int HDR_LANES  = `ASM_HDR_BYTES;
    localparam int LOW_LANES  = `ASM_BEAT_BYTES - `ASM_HDR_BYTES;
    localparam int HDR_BITS   = HDR_LANES * 8;
    localparam int LOW_BITS   = LOW_LANES * 8;
    // cycles allowed between the last input beat and out_last
    localparam int FRAME_WAIT = 20;
    // run budget covers 10 frames and 21 beats with gaps of up to 3 idle cycles
    localparam int FRAME_COST = 4 + `ASM_CSUM_LAT + 3 + FRAME_WAIT + 4;
    localparam int RUN_CYCLES = 20 + 10 * FRAME_COST + 21 * 4 + 50;

    logic    clk, rst;
    logic    len_load, hdr_load, in_valid, in_last;
    word16_t len_in;
    hdr_t    hdr_in;
    beat_t   in_data;
    keep_t   in_keep;
    logic    out_valid, out_last;
    beat_t   out_data;
    keep_t   out_keep;

    logic [31:0] lfsr_state;
    int          cyc = 0;
    int          mismatches;
    int          failures;
    bit          last_seen;
    beat_t       cap_data [$];
    keep_t       cap_keep [$];
    bit          cap_last [$];
    int          cap_cyc [$];

    tb_clock #(.PERIOD_NS(PERIOD), .RESET_CYCLES(4)) clock_gen (.clk(clk), .rst(rst));

    stream_assembler stream_assembler_inst (
        .clk(clk), .rst(rst),
        .len_load(len_load), .len_in(len_in), .hdr_load(hdr_load), .hdr_in(hdr_in),
        .in_valid(in_valid), .in_data(in_data), .in_keep(in_keep), .in_last(in_last),
        .out_valid(out_valid), .out_data(out_data), .out_keep(out_keep), .out_last(out_last)
    );

    always @(posedge clk) cyc <= cyc + 1;

    // output beats are taken at the falling edge away from the register updates
    always @(negedge clk) begin
        if (!rst && out_valid === 1'b1) begin
            cap_data.push_back(out_data);
            cap_keep.push_back(out_keep);
            cap_last.push_back(out_last);
            cap_cyc.push_back(cyc);
            if (out_last === 1'b1) last_seen = 1'b1;
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) r = {r[30:0], lfsr_step()};
        return r;
    endfunction

    function automatic hdr_t random_header();
        hdr_t h;
        for (int i = 0; i < HDR_LANES; i++) h[8*i +: 8] = 8'(rand_bits(8));
        return h;
    endfunction

    function automatic beat_t lane_mask(keep_t k);
        beat_t m;
        for (int i = 0; i < `ASM_BEAT_BYTES; i++) m[8*i +: 8] = {8{k[i]}};
        return m;
    endfunction

    function automatic hdr_t with_field(hdr_t h, int ofs, word16_t w);
        h[8*ofs +: 8]     = w[15:8];
        h[8*(ofs+1) +: 8] = w[7:0];
        return h;
    endfunction

    // ipv4 words at bytes 14..33 with the length replaced and the checksum word as zero
    function automatic word16_t ref_checksum(hdr_t h, word16_t len);
        int unsigned s;
        s = 0;
        for (int b = `ASM_IP_BASE; b < HDR_LANES; b += 2) begin
            if (b == `ASM_IP_LEN_OFS) s += len;
            else if (b != `ASM_IP_CSUM_OFS) s += {h[8*b +: 8], h[8*(b+1) +: 8]};
        end
        while (s > 32'hffff) s = (s & 32'hffff) + (s >> 16);
        return ~s[15:0];
    endfunction

    task automatic drive_idle();
        in_valid = 1'b0;
        in_data  = '0;
        in_keep  = '0;
        in_last  = 1'b0;
    endtask

    task automatic load_header(input word16_t len, input hdr_t hdr);
        @(negedge clk);
        len_load = 1'b1;
        len_in   = len;
        @(negedge clk);
        len_load = 1'b0;
        hdr_load = 1'b1;
        hdr_in   = hdr;
        @(negedge clk);
        hdr_load = 1'b0;
        repeat (`ASM_CSUM_LAT + 2) @(negedge clk);
    endtask

    task automatic run_frame(input string name, input word16_t len, input hdr_t hdr,
                             input int nbeats, input int last_lanes, input bit with_gaps);
        beat_t   in_beats [$];
        keep_t   in_keeps [$];
        int      drive_cyc [$];
        beat_t   exp_data [$];
        keep_t   exp_keep [$];
        bit      exp_last [$];
        int      exp_cyc [$];
        hdr_t    merged;
        word16_t ck;
        word16_t field;
        beat_t   d;
        keep_t   k;
        int      gap;
        int      waited;
        int      n;
        bit      flush;

        cap_data.delete();
        cap_keep.delete();
        cap_last.delete();
        cap_cyc.delete();
        last_seen = 1'b0;
        load_header(len, hdr);
        ck     = ref_checksum(hdr, len);
        merged = with_field(with_field(hdr, `ASM_IP_LEN_OFS, len), `ASM_IP_CSUM_OFS, ck);

        for (int j = 0; j < nbeats; j++) begin
            k = (j < nbeats - 1 || last_lanes == `ASM_BEAT_BYTES) ?
                '1 : ((keep_t'(1) << last_lanes) - 1'b1);
            for (int i = 0; i < `ASM_BEAT_BYTES; i++) d[8*i +: 8] = 8'(rand_bits(8));
            d = d & lane_mask(k);
            @(negedge clk);
            in_valid = 1'b1;
            in_data  = d;
            in_keep  = k;
            in_last  = (j == nbeats - 1);
            in_beats.push_back(d);
            in_keeps.push_back(k);
            drive_cyc.push_back(cyc);
            // a gapped frame always leaves one or two idle cycles between beats
            gap = (with_gaps && j < nbeats - 1) ? 1 + rand_bits(1) : 0;
            repeat (gap) begin
                @(negedge clk);
                drive_idle();
            end
        end
        @(negedge clk);
        drive_idle();

        // lanes 0-33 take the header or the carried top lanes, 34-63 the low input lanes
        flush = |in_keeps[nbeats-1][`ASM_BEAT_BYTES-1:LOW_LANES];
        for (int j = 0; j < nbeats; j++) begin
            d = '0;
            k = '0;
            d[HDR_BITS +: LOW_BITS]   = in_beats[j][0 +: LOW_BITS];
            k[HDR_LANES +: LOW_LANES] = in_keeps[j][0 +: LOW_LANES];
            d[0 +: HDR_BITS]  = (j == 0) ? merged : in_beats[j-1][LOW_BITS +: HDR_BITS];
            k[0 +: HDR_LANES] = (j == 0) ? '1 : in_keeps[j-1][LOW_LANES +: HDR_LANES];
            exp_data.push_back(d);
            exp_keep.push_back(k);
            exp_last.push_back(j == nbeats - 1 && !flush);
            exp_cyc.push_back(drive_cyc[j] + 2);
        end
        if (flush) begin
            d = '0;
            k = '0;
            d[0 +: HDR_BITS]  = in_beats[nbeats-1][LOW_BITS +: HDR_BITS];
            k[0 +: HDR_LANES] = in_keeps[nbeats-1][LOW_LANES +: HDR_LANES];
            exp_data.push_back(d);
            exp_keep.push_back(k);
            exp_last.push_back(1'b1);
            exp_cyc.push_back(drive_cyc[nbeats-1] + 3);
        end

        waited = 0;
        while (!last_seen && waited < FRAME_WAIT) begin
            @(posedge clk);
            waited++;
        end
        repeat (3) @(posedge clk);

        if (!last_seen) begin
            $display("%s: out_last did not arrive within %0d cycles", name, FRAME_WAIT);
            failures++;
        end
        if (cap_data.size() != exp_data.size()) begin
            $display("%s: expected %0d output beats but got %0d", name,
                     exp_data.size(), cap_data.size());
            failures++;
        end
        if (cap_data.size() > 0) begin
            field = {cap_data[0][8*`ASM_IP_LEN_OFS +: 8], cap_data[0][8*`ASM_IP_LEN_OFS+8 +: 8]};
            if (field !== len) begin
                $display("mismatch at %0t: %s out_data length field expected %h got %h",
                         $time, name, len, field);
                mismatches++;
            end
            field = {cap_data[0][8*`ASM_IP_CSUM_OFS +: 8],
                     cap_data[0][8*`ASM_IP_CSUM_OFS+8 +: 8]};
            if (field !== ck) begin
                $display("mismatch at %0t: %s out_data checksum field expected %h got %h",
                         $time, name, ck, field);
                mismatches++;
            end
        end
        n = (cap_data.size() < exp_data.size()) ? cap_data.size() : exp_data.size();
        for (int j = 0; j < n; j++) begin
            d = lane_mask(exp_keep[j]);
            if ((cap_data[j] & d) !== exp_data[j]) begin
                $display("mismatch at %0t: %s beat %0d out_data expected %h got %h",
                         $time, name, j, exp_data[j], cap_data[j] & d);
                mismatches++;
            end
            if (cap_keep[j] !== exp_keep[j]) begin
                $display("mismatch at %0t: %s beat %0d out_keep expected %h got %h",
                         $time, name, j, exp_keep[j], cap_keep[j]);
                mismatches++;
            end
            if (cap_last[j] !== exp_last[j]) begin
                $display("mismatch at %0t: %s beat %0d out_last expected %b got %b",
                         $time, name, j, exp_last[j], cap_last[j]);
                mismatches++;
            end
            if (cap_cyc[j] != exp_cyc[j]) begin
                $display("mismatch at %0t: %s beat %0d out_valid cycle expected %0d got %0d",
                         $time, name, j, exp_cyc[j], cap_cyc[j]);
                mismatches++;
            end
        end
    endtask

    task automatic reset_then_single_beat();
        repeat (8) begin
            @(negedge clk);
            if (out_valid !== 1'b0 || out_last !== 1'b0) begin
                $display("mismatch at %0t: out_valid/out_last expected 0/0 got %b/%b",
                         $time, out_valid, out_last);
                mismatches++;
            end
        end
        run_frame("single beat", 16'(rand_bits(16)), random_header(), 1, 20, 1'b0);
    endtask

    task automatic checksum_fields();
        run_frame("random header a", 16'(rand_bits(16)), random_header(), 1, 8, 1'b0);
        run_frame("random header b", 16'(rand_bits(16)), random_header(), 1, 25, 1'b0);
        // every word 0xffff gives many carries to fold
        run_frame("all-ones header", 16'hffff, '1, 1, 10, 1'b0);
        run_frame("all-zero header", 16'h0000, '0, 1, 10, 1'b0);
    endtask

    task automatic flush_beat_frame();
        run_frame("flush beat", 16'(rand_bits(16)), random_header(), 4, 40, 1'b0);
    endtask

    task automatic exact_fit_frame();
        run_frame("exact fit", 16'(rand_bits(16)), random_header(), 3, LOW_LANES, 1'b0);
    endtask

    task automatic gapped_frame();
        run_frame("gapped frame", 16'(rand_bits(16)), random_header(), 5, 50, 1'b1);
    endtask

    task automatic back_to_back_frames();
        run_frame("first of pair", 16'(rand_bits(16)), random_header(), 2, 64, 1'b0);
        run_frame("second of pair", 16'(rand_bits(16)), random_header(), 2, 12, 1'b0);
    endtask

    initial begin
        lfsr_state = 32'h71562554;
        mismatches = 0;
        failures   = 0;
        last_seen  = 1'b0;
        len_load   = 1'b0;
        len_in     = '0;
        hdr_load   = 1'b0;
        hdr_in     = '0;
        drive_idle();
        wait (rst === 1'b0);
        reset_then_single_beat();
        checksum_fields();
        flush_beat_frame();
        exact_fit_frame();
        gapped_frame();
        back_to_back_frames();
        $display("summary: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches + failures == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        #(RUN_CYCLES * PERIOD);
        $display("watchdog expired after %0d cycles, the tests did not complete", RUN_CYCLES);
        $display("summary: %0d mismatches, %0d other failures", mismatches, failures + 1);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

/* list.f */
+incdir+verilog
verilog/asm_pkg.sv
verilog/stage_pipe.sv
verilog/csum_tree.sv
verilog/beat_realigner.sv
verilog/header_merge.sv
verilog/stream_assembler.sv
sim/tb_clock.sv
sim/stream_assembler_tb.sv
